/* include/exec_defs.svh */
`ifndef EXEC_DEFS_SVH
`define EXEC_DEFS_SVH

// integer register and address width
`define EXEC_XLEN 64

// width of the *w operations, results sign extend from bit 31
`define EXEC_WLEN 32

// destination register index width, x0 through x31
`define EXEC_RADDR_W 5

// shift amount for sh1add/sh2add/sh3add
`define EXEC_SLA_W 2

`endif

/* verilog/exec_pkg.sv */
`default_nettype none

package exec_pkg;

    // operation code on the issue port
    typedef enum logic [4:0] {
        ADD    = 5'd0,
        SUB    = 5'd1,
        ADDW   = 5'd2,
        SUBW   = 5'd3,
        SLT    = 5'd4,
        SLTU   = 5'd5,
        MIN    = 5'd6,
        MAX    = 5'd7,
        MINU   = 5'd8,
        MAXU   = 5'd9,
        AND    = 5'd10,
        OR     = 5'd11,
        XOR    = 5'd12,
        ANDN   = 5'd13,
        ORN    = 5'd14,
        XNOR   = 5'd15,
        SH1ADD = 5'd16,
        SH2ADD = 5'd17,
        SH3ADD = 5'd18,
        // conditional branches, resolved in the arithmetic unit
        BEQ    = 5'd19,
        BNE    = 5'd20,
        BLT    = 5'd21,
        BGE    = 5'd22,
        BLTU   = 5'd23,
        BGEU   = 5'd24
    } exec_op_e;

    // arithmetic unit result select
    typedef enum logic [1:0] {
        ARITH_ADD = 2'd0,
        ARITH_SLT = 2'd1,
        ARITH_CMP = 2'd2
    } arith_sel_e;

    // logic unit result select
    typedef enum logic [1:0] {
        LOGIC_AND = 2'd0,
        LOGIC_OR  = 2'd1,
        LOGIC_XOR = 2'd2,
        LOGIC_SLA = 2'd3
    } logic_sel_e;

endpackage

`default_nettype wire

/* verilog/exec_decode.sv */
`default_nettype none
`timescale 1ns/1ps
`include "exec_defs.svh"

module exec_decode (
    input  logic                     i_valid,
    input  exec_pkg::exec_op_e       i_op,
    // unit issue, at most one high per cycle
    output logic                     o_arith_valid,
    output logic                     o_logic_valid,
    // arithmetic unit controls
    output exec_pkg::arith_sel_e     o_arith_sel,
    output logic                     o_sub,
    output logic                     o_unsigned,
    output logic                     o_cmp_min,
    output logic                     o_word,
    output logic                     o_branch_en,
    output logic                     o_branch_equal,
    output logic                     o_branch_invert,
    // logic unit controls
    output exec_pkg::logic_sel_e     o_logic_sel,
    output logic                     o_invert,
    output logic [`EXEC_SLA_W-1:0]   o_sla_amount
);
    always_comb begin
        // idle defaults, an unknown code issues to neither unit
        o_arith_valid   = 1'b0;
        o_logic_valid   = 1'b0;
        o_arith_sel     = exec_pkg::ARITH_ADD;
        o_sub           = 1'b0;
        o_unsigned      = 1'b0;
        o_cmp_min       = 1'b0;
        o_word          = 1'b0;
        o_branch_en     = 1'b0;
        o_branch_equal  = 1'b0;
        o_branch_invert = 1'b0;
        o_logic_sel     = exec_pkg::LOGIC_AND;
        o_invert        = 1'b0;
        o_sla_amount    = '0;

        case (i_op)
            exec_pkg::ADD, exec_pkg::SUB, exec_pkg::ADDW, exec_pkg::SUBW: begin
                o_arith_valid = i_valid;
                o_sub  = (i_op == exec_pkg::SUB) || (i_op == exec_pkg::SUBW);
                o_word = (i_op == exec_pkg::ADDW) || (i_op == exec_pkg::SUBW);
            end
            exec_pkg::SLT, exec_pkg::SLTU: begin
                // less-than needs the subtract carry out
                o_arith_valid = i_valid;
                o_arith_sel   = exec_pkg::ARITH_SLT;
                o_sub         = 1'b1;
                o_unsigned    = (i_op == exec_pkg::SLTU);
            end
            exec_pkg::MIN, exec_pkg::MAX, exec_pkg::MINU, exec_pkg::MAXU: begin
                o_arith_valid = i_valid;
                o_arith_sel   = exec_pkg::ARITH_CMP;
                o_sub         = 1'b1;
                o_unsigned    = (i_op == exec_pkg::MINU) || (i_op == exec_pkg::MAXU);
                o_cmp_min     = (i_op == exec_pkg::MIN) || (i_op == exec_pkg::MINU);
            end
            exec_pkg::BEQ, exec_pkg::BNE, exec_pkg::BLT,
            exec_pkg::BGE, exec_pkg::BLTU, exec_pkg::BGEU: begin
                // subtract so the adder top bit gives less-than
                o_arith_valid   = i_valid;
                o_sub           = 1'b1;
                o_branch_en     = 1'b1;
                o_unsigned      = (i_op == exec_pkg::BLTU) || (i_op == exec_pkg::BGEU);
                o_branch_equal  = (i_op == exec_pkg::BEQ) || (i_op == exec_pkg::BNE);
                // ne, ge and geu are the negated eq, lt and ltu
                o_branch_invert = (i_op == exec_pkg::BNE) || (i_op == exec_pkg::BGE) ||
                                  (i_op == exec_pkg::BGEU);
            end
            exec_pkg::AND, exec_pkg::ANDN: begin
                o_logic_valid = i_valid;
                o_invert      = (i_op == exec_pkg::ANDN);
            end
            exec_pkg::OR, exec_pkg::ORN: begin
                o_logic_valid = i_valid;
                o_logic_sel   = exec_pkg::LOGIC_OR;
                o_invert      = (i_op == exec_pkg::ORN);
            end
            exec_pkg::XOR, exec_pkg::XNOR: begin
                o_logic_valid = i_valid;
                o_logic_sel   = exec_pkg::LOGIC_XOR;
                o_invert      = (i_op == exec_pkg::XNOR);
            end
            exec_pkg::SH1ADD, exec_pkg::SH2ADD, exec_pkg::SH3ADD: begin
                o_logic_valid = i_valid;
                o_logic_sel   = exec_pkg::LOGIC_SLA;
                if (i_op == exec_pkg::SH1ADD) begin
                    o_sla_amount = `EXEC_SLA_W'd1;
                end else if (i_op == exec_pkg::SH2ADD) begin
                    o_sla_amount = `EXEC_SLA_W'd2;
                end else begin
                    o_sla_amount = `EXEC_SLA_W'd3;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/exec_arith.sv */
`default_nettype none
`timescale 1ns/1ps
`include "exec_defs.svh"

// add/sub, set-less-than, min/max and branch resolution, one cycle
module exec_arith (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  logic                      i_valid,
    input  logic [`EXEC_XLEN-1:0]     i_op1,
    input  logic [`EXEC_XLEN-1:0]     i_op2,
    // carried along for writeback
    input  logic [`EXEC_RADDR_W-1:0]  i_rd,
    // pc of the branch and of the fall-through instruction
    input  logic [`EXEC_XLEN-1:0]     i_pc,
    input  logic [`EXEC_XLEN-1:0]     i_pc_next,
    input  logic [`EXEC_XLEN-1:0]     i_branch_offset,
    input  exec_pkg::arith_sel_e      i_arith_sel,
    input  logic                      i_sub,
    input  logic                      i_unsigned,
    input  logic                      i_cmp_min,
    input  logic                      i_word,
    input  logic                      i_branch_en,
    input  logic                      i_branch_equal,
    input  logic                      i_branch_invert,
    output logic                      o_valid,
    output logic [`EXEC_XLEN-1:0]     o_result,
    output logic [`EXEC_RADDR_W-1:0]  o_rd,
    output logic                      o_branch,
    output logic [`EXEC_XLEN-1:0]     o_branch_target
);
    logic [`EXEC_XLEN:0]   add_op1;
    logic [`EXEC_XLEN:0]   add_op2;
    logic [`EXEC_XLEN:0]   sum;
    logic [`EXEC_XLEN-1:0] add_result;
    logic                  lt;
    logic                  eq;
    logic                  branch;
    logic [`EXEC_XLEN-1:0] branch_target;
    logic [`EXEC_XLEN-1:0] result;

    // one extra bit, sign or zero extended, so the top bit is op1 < op2
    assign add_op1 = {i_op1[`EXEC_XLEN-1] & ~i_unsigned, i_op1};
    // two's complement negate is invert plus carry in
    assign add_op2 = {i_op2[`EXEC_XLEN-1] & ~i_unsigned, i_op2} ^ {(`EXEC_XLEN+1){i_sub}};
    assign sum     = add_op1 + add_op2 + {{`EXEC_XLEN{1'b0}}, i_sub};
    assign lt      = sum[`EXEC_XLEN];

    // word forms keep the low 32 bits and sign extend
    assign add_result = i_word ?
        {{(`EXEC_XLEN-`EXEC_WLEN){sum[`EXEC_WLEN-1]}}, sum[`EXEC_WLEN-1:0]} :
        sum[`EXEC_XLEN-1:0];

    always_comb begin
        case (i_arith_sel)
            exec_pkg::ARITH_SLT: result = {{(`EXEC_XLEN-1){1'b0}}, lt};
            // min picks op1 when less, max picks op2 when less
            exec_pkg::ARITH_CMP: result = (lt ^ i_cmp_min) ? i_op2 : i_op1;
            default:             result = add_result;
        endcase
    end

    // branch condition, eq or lt then optional negate
    assign eq     = (i_op1 == i_op2);
    assign branch = i_branch_en & ((i_branch_equal ? eq : lt) ^ i_branch_invert);

    // not taken falls through to the next pc
    assign branch_target = branch ? (i_pc + i_branch_offset) : i_pc_next;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid         <= 1'b0;
            o_result        <= '0;
            o_rd            <= '0;
            o_branch        <= 1'b0;
            o_branch_target <= '0;
        end else begin
            o_valid         <= i_valid;
            // a branch writes no register, drop the compare difference
            o_result        <= i_branch_en ? '0 : result;
            o_rd            <= i_rd;
            o_branch        <= branch;
            o_branch_target <= branch_target;
        end
    end

endmodule

`default_nettype wire

/* verilog/exec_logic.sv */
`default_nettype none
`timescale 1ns/1ps
`include "exec_defs.svh"

// bitwise ops and shift-add address generation, one cycle
module exec_logic (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  logic                      i_valid,
    input  logic [`EXEC_XLEN-1:0]     i_op1,
    input  logic [`EXEC_XLEN-1:0]     i_op2,
    input  logic [`EXEC_RADDR_W-1:0]  i_rd,
    input  exec_pkg::logic_sel_e      i_logic_sel,
    // andn, orn and xnor
    input  logic                      i_invert,
    // op1 shift for shNadd
    input  logic [`EXEC_SLA_W-1:0]    i_sla_amount,
    output logic                      o_valid,
    output logic [`EXEC_XLEN-1:0]     o_result,
    output logic [`EXEC_RADDR_W-1:0]  o_rd
);
    logic [`EXEC_XLEN-1:0] op2;
    logic [`EXEC_XLEN-1:0] sl2;
    logic [`EXEC_XLEN-1:0] sl1;
    logic [`EXEC_XLEN-1:0] result;

    assign op2 = i_op2 ^ {`EXEC_XLEN{i_invert}};

    // shift by 2 then by 1, covers 0 to 3
    assign sl2 = i_sla_amount[1] ? {i_op1[`EXEC_XLEN-3:0], 2'b00} : i_op1;
    assign sl1 = i_sla_amount[0] ? {sl2[`EXEC_XLEN-2:0], 1'b0} : sl2;

    always_comb begin
        case (i_logic_sel)
            exec_pkg::LOGIC_OR:  result = i_op1 | op2;
            exec_pkg::LOGIC_XOR: result = i_op1 ^ op2;
            // base times 2/4/8 plus offset, offset never inverted
            exec_pkg::LOGIC_SLA: result = sl1 + i_op2;
            default:             result = i_op1 & op2;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid  <= 1'b0;
            o_result <= '0;
            o_rd     <= '0;
        end else begin
            o_valid  <= i_valid;
            o_result <= result;
            o_rd     <= i_rd;
        end
    end

endmodule

`default_nettype wire

/* verilog/exec_writeback.sv */
`default_nettype none
`timescale 1ns/1ps
`include "exec_defs.svh"

// merges the unit results into the one result port
module exec_writeback (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  logic                      i_arith_valid,
    input  logic [`EXEC_XLEN-1:0]     i_arith_result,
    input  logic [`EXEC_RADDR_W-1:0]  i_arith_rd,
    input  logic                      i_arith_branch,
    input  logic [`EXEC_XLEN-1:0]     i_arith_target,
    input  logic                      i_logic_valid,
    input  logic [`EXEC_XLEN-1:0]     i_logic_result,
    input  logic [`EXEC_RADDR_W-1:0]  i_logic_rd,
    output logic                      o_valid,
    output logic [`EXEC_XLEN-1:0]     o_result,
    output logic [`EXEC_RADDR_W-1:0]  o_rd,
    output logic                      o_branch,
    output logic [`EXEC_XLEN-1:0]     o_branch_target
);
    logic [`EXEC_XLEN-1:0]    sel_result;
    logic [`EXEC_RADDR_W-1:0] sel_rd;
    logic                     branch;

    // the units never complete in the same cycle
    assign sel_result = i_arith_valid ? i_arith_result : i_logic_result;
    assign sel_rd     = i_arith_valid ? i_arith_rd : i_logic_rd;
    assign branch     = i_arith_valid & i_arith_branch;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid         <= 1'b0;
            o_result        <= '0;
            o_rd            <= '0;
            o_branch        <= 1'b0;
            o_branch_target <= '0;
        end else begin
            o_valid         <= i_arith_valid | i_logic_valid;
            // x0 reads as zero, and a branch has nothing to write
            o_result        <= ((sel_rd == '0) || branch) ? '0 : sel_result;
            o_rd            <= sel_rd;
            o_branch        <= branch;
            o_branch_target <= i_arith_valid ? i_arith_target : '0;
        end
    end

endmodule

`default_nettype wire

/* verilog/exec_top.sv */
`default_nettype none
`timescale 1ns/1ps
`include "exec_defs.svh"

// execute cluster, two cycles from issue to result, one issue per cycle
module exec_top (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    // issue port, accepted whenever valid is high
    input  logic                      i_valid,
    input  exec_pkg::exec_op_e        i_op,
    input  logic [`EXEC_XLEN-1:0]     i_op1,
    input  logic [`EXEC_XLEN-1:0]     i_op2,
    input  logic [`EXEC_RADDR_W-1:0]  i_rd,
    input  logic [`EXEC_XLEN-1:0]     i_pc,
    input  logic [`EXEC_XLEN-1:0]     i_pc_next,
    input  logic [`EXEC_XLEN-1:0]     i_branch_offset,
    // result port
    output logic                      o_valid,
    output logic [`EXEC_XLEN-1:0]     o_result,
    output logic [`EXEC_RADDR_W-1:0]  o_rd,
    output logic                      o_branch,
    output logic [`EXEC_XLEN-1:0]     o_branch_target
);
    // decode to units
    logic                     arith_valid;
    logic                     logic_valid;
    exec_pkg::arith_sel_e     arith_sel;
    logic                     sub;
    logic                     cmp_unsigned;
    logic                     cmp_min;
    logic                     word;
    logic                     branch_en;
    logic                     branch_equal;
    logic                     branch_invert;
    exec_pkg::logic_sel_e     logic_sel;
    logic                     invert;
    logic [`EXEC_SLA_W-1:0]   sla_amount;

    // units to writeback
    logic                     ar_valid;
    logic [`EXEC_XLEN-1:0]    ar_result;
    logic [`EXEC_RADDR_W-1:0] ar_rd;
    logic                     ar_branch;
    logic [`EXEC_XLEN-1:0]    ar_target;
    logic                     lg_valid;
    logic [`EXEC_XLEN-1:0]    lg_result;
    logic [`EXEC_RADDR_W-1:0] lg_rd;

    exec_decode u_decode (
        .i_valid         (i_valid),
        .i_op            (i_op),
        .o_arith_valid   (arith_valid),
        .o_logic_valid   (logic_valid),
        .o_arith_sel     (arith_sel),
        .o_sub           (sub),
        .o_unsigned      (cmp_unsigned),
        .o_cmp_min       (cmp_min),
        .o_word          (word),
        .o_branch_en     (branch_en),
        .o_branch_equal  (branch_equal),
        .o_branch_invert (branch_invert),
        .o_logic_sel     (logic_sel),
        .o_invert        (invert),
        .o_sla_amount    (sla_amount)
    );

    exec_arith u_arith (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_valid         (arith_valid),
        .i_op1           (i_op1),
        .i_op2           (i_op2),
        .i_rd            (i_rd),
        .i_pc            (i_pc),
        .i_pc_next       (i_pc_next),
        .i_branch_offset (i_branch_offset),
        .i_arith_sel     (arith_sel),
        .i_sub           (sub),
        .i_unsigned      (cmp_unsigned),
        .i_cmp_min       (cmp_min),
        .i_word          (word),
        .i_branch_en     (branch_en),
        .i_branch_equal  (branch_equal),
        .i_branch_invert (branch_invert),
        .o_valid         (ar_valid),
        .o_result        (ar_result),
        .o_rd            (ar_rd),
        .o_branch        (ar_branch),
        .o_branch_target (ar_target)
    );

    exec_logic u_logic (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_valid      (logic_valid),
        .i_op1        (i_op1),
        .i_op2        (i_op2),
        .i_rd         (i_rd),
        .i_logic_sel  (logic_sel),
        .i_invert     (invert),
        .i_sla_amount (sla_amount),
        .o_valid      (lg_valid),
        .o_result     (lg_result),
        .o_rd         (lg_rd)
    );

    exec_writeback u_writeback (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_arith_valid   (ar_valid),
        .i_arith_result  (ar_result),
        .i_arith_rd      (ar_rd),
        .i_arith_branch  (ar_branch),
        .i_arith_target  (ar_target),
        .i_logic_valid   (lg_valid),
        .i_logic_result  (lg_result),
        .i_logic_rd      (lg_rd),
        .o_valid         (o_valid),
        .o_result        (o_result),
        .o_rd            (o_rd),
        .o_branch        (o_branch),
        .o_branch_target (o_branch_target)
    );

endmodule

`default_nettype wire

/* bench/exec_clkgen.sv */
`default_nettype none
`timescale 1ns/1ps

// testbench clock and power-on reset
module exec_clkgen (
    output logic o_clk,
    output logic o_rst_n
);
    // 8 ns period
    initial begin
        o_clk = 1'b0;
        forever #4 o_clk = ~o_clk;
    end

    // reset held low for the first 3 rising edges
    initial begin
        o_rst_n = 1'b0;
        repeat (3) @(posedge o_clk);
        o_rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

/* bench/tb_exec.sv */
`default_nettype none
`timescale 1ns/1ps
`include "exec_defs.svh"

module tb_exec;

    localparam int N_RAND = 4;
    // arith random and boundary, logic, branch, x0 and back-to-back issues
    localparam int ISSUE_COUNT = 10 * N_RAND + 10 * 4 + 9 * N_RAND + 6 * 4 + 4 + 8;
    localparam int WATCHDOG_NS = ISSUE_COUNT * 8 * 4;
    // back-to-back issue slots, bit s set means slot s issues
    localparam logic [11:0] B2B_MASK = 12'b0111_0011_0111;

    logic                     clk;
    logic                     rst_n;
    logic                     in_valid;
    exec_pkg::exec_op_e       in_op;
    logic [`EXEC_XLEN-1:0]    in_op1;
    logic [`EXEC_XLEN-1:0]    in_op2;
    logic [`EXEC_RADDR_W-1:0] in_rd;
    logic [`EXEC_XLEN-1:0]    in_pc;
    logic [`EXEC_XLEN-1:0]    in_pc_next;
    logic [`EXEC_XLEN-1:0]    in_offset;
    logic                     out_valid;
    logic [`EXEC_XLEN-1:0]    out_result;
    logic [`EXEC_RADDR_W-1:0] out_rd;
    logic                     out_branch;
    logic [`EXEC_XLEN-1:0]    out_branch_target;
    logic [63:0]              lcg_state;
    int                       test_errs;
    int                       pass_count;
    int                       fail_count;

    exec_clkgen u_clkgen (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    exec_top dut (
        .i_clk           (clk),
        .i_rst_n         (rst_n),
        .i_valid         (in_valid),
        .i_op            (in_op),
        .i_op1           (in_op1),
        .i_op2           (in_op2),
        .i_rd            (in_rd),
        .i_pc            (in_pc),
        .i_pc_next       (in_pc_next),
        .i_branch_offset (in_offset),
        .o_valid         (out_valid),
        .o_result        (out_result),
        .o_rd            (out_rd),
        .o_branch        (out_branch),
        .o_branch_target (out_branch_target)
    );

    // 64-bit lcg, halves swapped so low bits are less regular
    function automatic logic [63:0] next_rand();
        lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
        return {lcg_state[31:0], lcg_state[63:32]};
    endfunction

    // destination in x1..x31
    function automatic logic [4:0] rand_rd();
        logic [63:0] r;
        r = next_rand() % 31;
        return r[4:0] + 5'd1;
    endfunction

    // expected result of an op, straight from the instruction definitions
    function automatic logic [63:0] expect_result(input exec_pkg::exec_op_e op,
                                                  input logic [63:0] a, input logic [63:0] b);
        logic [63:0] s;
        logic [63:0] d;
        logic        lts;
        logic        ltu;
        s   = a + b;
        d   = a - b;
        lts = $signed(a) < $signed(b);
        ltu = a < b;
        case (op)
            exec_pkg::ADD:    return s;
            exec_pkg::SUB:    return d;
            exec_pkg::ADDW:   return {{32{s[31]}}, s[31:0]};
            exec_pkg::SUBW:   return {{32{d[31]}}, d[31:0]};
            exec_pkg::SLT:    return lts ? 64'd1 : 64'd0;
            exec_pkg::SLTU:   return ltu ? 64'd1 : 64'd0;
            exec_pkg::MIN:    return lts ? a : b;
            exec_pkg::MAX:    return lts ? b : a;
            exec_pkg::MINU:   return ltu ? a : b;
            exec_pkg::MAXU:   return ltu ? b : a;
            exec_pkg::AND:    return a & b;
            exec_pkg::OR:     return a | b;
            exec_pkg::XOR:    return a ^ b;
            exec_pkg::ANDN:   return a & ~b;
            exec_pkg::ORN:    return a | ~b;
            exec_pkg::XNOR:   return ~(a ^ b);
            exec_pkg::SH1ADD: return (a << 1) + b;
            exec_pkg::SH2ADD: return (a << 2) + b;
            exec_pkg::SH3ADD: return (a << 3) + b;
            // branches write nothing
            default:          return 64'd0;
        endcase
    endfunction

    function automatic logic expect_taken(input exec_pkg::exec_op_e op,
                                          input logic [63:0] a, input logic [63:0] b);
        case (op)
            exec_pkg::BEQ:  return a == b;
            exec_pkg::BNE:  return a != b;
            exec_pkg::BLT:  return $signed(a) < $signed(b);
            exec_pkg::BGE:  return $signed(a) >= $signed(b);
            exec_pkg::BLTU: return a < b;
            exec_pkg::BGEU: return a >= b;
            default:        return 1'b0;
        endcase
    endfunction

    // logic unit ops carry no target, everything else goes through arith
    function automatic logic uses_arith(input exec_pkg::exec_op_e op);
        case (op)
            exec_pkg::AND, exec_pkg::OR, exec_pkg::XOR, exec_pkg::ANDN, exec_pkg::ORN,
            exec_pkg::XNOR, exec_pkg::SH1ADD, exec_pkg::SH2ADD, exec_pkg::SH3ADD:
                return 1'b0;
            default:
                return 1'b1;
        endcase
    endfunction

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (actual !== expected) begin
            $display("ERR %s expected %h actual %h at %0t", name, expected, actual, $time);
            test_errs = test_errs + 1;
        end
    endtask

    task automatic end_test(input string name);
        if (test_errs == 0) begin
            pass_count = pass_count + 1;
            $display("test %s passed", name);
        end else begin
            fail_count = fail_count + 1;
            $display("test %s failed with %0d mismatches", name, test_errs);
        end
        test_errs = 0;
    endtask

    // one issue, then the full result port two edges later
    task automatic run_op(input exec_pkg::exec_op_e op, input logic [63:0] a,
                          input logic [63:0] b, input logic [4:0] rd);
        logic [63:0] r;
        logic [63:0] pc;
        logic [63:0] pc_next;
        logic [63:0] off;
        logic [63:0] exp_res;
        logic [63:0] exp_tgt;
        logic        taken;
        r       = next_rand();
        pc      = {r[63:2], 2'b00};
        pc_next = pc + 64'd4;
        // signed 13-bit even offset like a b-type immediate
        off     = {{51{r[12]}}, r[12:1], 1'b0};
        @(posedge clk);
        in_valid   <= 1'b1;
        in_op      <= op;
        in_op1     <= a;
        in_op2     <= b;
        in_rd      <= rd;
        in_pc      <= pc;
        in_pc_next <= pc_next;
        in_offset  <= off;
        // idle slot after the previous issue, a stale branch must not leak out
        @(negedge clk);
        check("o_valid", 64'd0, out_valid);
        check("o_branch", 64'd0, out_branch);
        @(posedge clk);
        in_valid <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        taken   = expect_taken(op, a, b);
        exp_res = (rd == 5'd0) ? 64'd0 : expect_result(op, a, b);
        exp_tgt = !uses_arith(op) ? 64'd0 : (taken ? pc + off : pc_next);
        check("o_valid", 64'd1, out_valid);
        check("o_result", exp_res, out_result);
        check("o_rd", rd, out_rd);
        check("o_branch", taken, out_branch);
        check("o_branch_target", exp_tgt, out_branch_target);
    endtask

    task automatic reset_state();
        @(negedge clk);
        check("o_valid", 64'd0, out_valid);
        check("o_branch", 64'd0, out_branch);
        check("o_result", 64'd0, out_result);
        wait (rst_n === 1'b1);
        @(negedge clk);
        check("o_valid", 64'd0, out_valid);
        check("o_branch", 64'd0, out_branch);
        check("o_result", 64'd0, out_result);
        end_test("reset_state");
    endtask

    task automatic arith_ops();
        logic [4:0]  k;
        int          i;
        logic [63:0] a;
        logic [63:0] b;
        for (k = 5'd0; k < 5'd10; k = k + 5'd1) begin
            for (i = 0; i < N_RAND; i = i + 1) begin
                a = next_rand();
                b = next_rand();
                run_op(exec_pkg::exec_op_e'(k), a, b, rand_rd());
            end
            // most negative against 1 both ways, then unsigned and word overflow edges
            for (i = 0; i < 4; i = i + 1) begin
                case (i)
                    0: {a, b} = {64'h8000_0000_0000_0000, 64'd1};
                    1: {a, b} = {64'd1, 64'h8000_0000_0000_0000};
                    2: {a, b} = {64'hffff_ffff_ffff_ffff, 64'd0};
                    default: {a, b} = {64'h0000_0000_7fff_ffff, 64'd1};
                endcase
                run_op(exec_pkg::exec_op_e'(k), a, b, rand_rd());
            end
        end
        end_test("arith_ops");
    endtask

    task automatic logic_ops();
        logic [4:0]  k;
        int          i;
        logic [63:0] a;
        logic [63:0] b;
        for (k = 5'd10; k < 5'd19; k = k + 5'd1) begin
            for (i = 0; i < N_RAND; i = i + 1) begin
                a = next_rand();
                b = next_rand();
                run_op(exec_pkg::exec_op_e'(k), a, b, rand_rd());
            end
        end
        end_test("logic_ops");
    endtask

    task automatic branch_ops();
        logic [4:0]  k;
        int          i;
        logic [63:0] a;
        logic [63:0] b;
        for (k = 5'd19; k < 5'd25; k = k + 5'd1) begin
            for (i = 0; i < 4; i = i + 1) begin
                case (i)
                    0: begin
                        a = next_rand();
                        b = a;
                    end
                    1: {a, b} = {64'd5, 64'd9};
                    2: {a, b} = {64'd9, 64'd5};
                    // less signed but greater unsigned
                    default: {a, b} = {64'hffff_ffff_ffff_ffff, 64'd1};
                endcase
                run_op(exec_pkg::exec_op_e'(k), a, b, rand_rd());
            end
        end
        end_test("branch_ops");
    endtask

    task automatic rd_zero();
        run_op(exec_pkg::ADD, next_rand(), 64'd7, 5'd0);
        run_op(exec_pkg::XOR, next_rand(), 64'h5555_0000_aaaa_ffff, 5'd0);
        run_op(exec_pkg::SH2ADD, 64'h100, next_rand(), 5'd0);
        run_op(exec_pkg::MAX, 64'h8000_0000_0000_0000, 64'd3, 5'd0);
        end_test("rd_zero");
    endtask

    // arith and logic alternate, gaps in between, results checked in slot order
    task automatic back_to_back();
        logic [63:0]        exp_res [12];
        logic [4:0]         exp_rd [12];
        logic               exp_valid [12];
        logic [63:0]        r;
        logic [63:0]        a;
        logic [63:0]        b;
        logic [4:0]         rd;
        logic [4:0]         code;
        exec_pkg::exec_op_e op;
        int                 s;
        int                 n_issued;
        n_issued = 0;
        for (s = 0; s < 14; s = s + 1) begin
            @(posedge clk);
            if (s < 12 && B2B_MASK[s]) begin
                r    = next_rand();
                code = (n_issued % 2 == 0) ? 5'(r % 10) : 5'(10 + r % 9);
                op   = exec_pkg::exec_op_e'(code);
                a    = next_rand();
                b    = next_rand();
                rd   = rand_rd();
                exp_valid[s] = 1'b1;
                exp_res[s]   = expect_result(op, a, b);
                exp_rd[s]    = rd;
                in_valid <= 1'b1;
                in_op    <= op;
                in_op1   <= a;
                in_op2   <= b;
                in_rd    <= rd;
                n_issued = n_issued + 1;
            end else begin
                in_valid <= 1'b0;
                if (s < 12) begin
                    exp_valid[s] = 1'b0;
                end
            end
            @(negedge clk);
            if (s >= 2) begin
                check("o_valid", exp_valid[s-2], out_valid);
                check("o_branch", 64'd0, out_branch);
                if (exp_valid[s-2]) begin
                    check("o_result", exp_res[s-2], out_result);
                    check("o_rd", exp_rd[s-2], out_rd);
                end
            end
        end
        end_test("back_to_back");
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: tests still running after %0d ns", WATCHDOG_NS);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        lcg_state  = 64'd34;
        test_errs  = 0;
        pass_count = 0;
        fail_count = 0;
        in_valid   = 1'b0;
        in_op      = exec_pkg::ADD;
        in_op1     = '0;
        in_op2     = '0;
        in_rd      = '0;
        in_pc      = '0;
        in_pc_next = '0;
        in_offset  = '0;
        reset_state();
        arith_ops();
        logic_ops();
        branch_ops();
        rd_zero();
        back_to_back();
        $display("tests passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+include
verilog/exec_pkg.sv
verilog/exec_decode.sv
verilog/exec_arith.sv
verilog/exec_logic.sv
verilog/exec_writeback.sv
verilog/exec_top.sv
bench/exec_clkgen.sv
bench/tb_exec.sv
